// ==== ibSwitch.f ====
rtl/ibBusPkg.sv
rtl/ibSwitchPkg.sv
rtl/ibInputPort.sv
rtl/ibOutputPort.sv
rtl/ibSwitch.sv
testbench/ibSwitchTb.sv

// ==== rtl/ibBusPkg.sv ====
`default_nettype none

package ibBusPkg;

  // ********************
  // link word layout
  // ********************
  localparam int dataW = 32;                   // payload bits per link word.
  localparam int sopPos = dataW;               // start flag sits just above the data.
  localparam int eopPos = dataW + 1;           // end flag above the start flag.
  localparam int entryW = dataW + 2;           // stored word with both flags.

  typedef logic [dataW-1:0] busData;           // one word on a link.
  typedef logic [dataW-1:0] busAddr;           // header word read as an address.
  typedef logic [entryW-1:0] bufEntry;         // {eop, sop, data} in a buffer slot.

  // ********************
  // address windows
  // ********************
  // a window is the aligned block of 2**bits addresses starting at base,
  // so only the bits above the window size take part in the compare.
  function automatic logic windowMatch(
    busAddr      addr,
    busAddr      base,
    int unsigned bits
  );
    busAddr addrHigh;
    busAddr baseHigh;
    addrHigh = addr >> bits;                   // drop the offset inside the window.
    baseHigh = base >> bits;                   // same for the window base.
    return addrHigh == baseHigh;
  endfunction

endpackage

`default_nettype wire

// ==== rtl/ibInputPort.sv ====
`timescale 1ns/1ns
`default_nettype none

module ibInputPort #(
  parameter int                  bufDepth   = 8,
  parameter ibSwitchPkg::portIdx port       = '0,
  parameter ibBusPkg::busAddr    port1Base  = 32'h0001_0000,
  parameter ibBusPkg::busAddr    port2Base  = 32'h0002_0000,
  parameter int                  windowBits = 16
) (
  input  logic                 CLK,
  input  logic                 rstN,
  input  ibBusPkg::busData     rxData,
  input  logic                 rxSop,
  input  logic                 rxEop,
  input  logic                 rxValid,
  input  logic                 pop,
  output logic                 rxCredit,
  output ibBusPkg::busData     headData,
  output logic                 headSop,
  output logic                 headEop,
  output logic                 headValid,
  output ibSwitchPkg::portMask headDest
);

  localparam int ptrW = $clog2(bufDepth);                  // pointer width, wraps naturally.
  localparam logic [ptrW:0] fullLvl = (ptrW + 1)'(bufDepth); // fill level of a full buffer.

  if ((1 << ptrW) != bufDepth) begin : genDepthCheck
    $error("ibInputPort: bufDepth must be a power of two");
  end

  ibBusPkg::bufEntry    mem [bufDepth];     // word storage, no reset.
  ibBusPkg::bufEntry    head;               // slot under the read pointer.
  logic [ptrW-1:0]      wrPtr;              // next slot to write.
  logic [ptrW-1:0]      rdPtr;              // current head slot.
  logic [ptrW:0]        fill;               // words held, 0 to bufDepth.
  logic                 hitPort1;           // header inside port 1 window.
  logic                 hitPort2;           // header inside port 2 window.
  ibSwitchPkg::portMask newDest;            // decode of the word at the head.
  ibSwitchPkg::portMask destReg;            // destination kept for the rest of a packet.
  logic                 drain;              // local discard of a dropped packet.
  logic                 doPop;              // head word leaves this cycle.

  // ********************
  // head of buffer
  // ********************
  assign head      = mem[rdPtr];
  assign headData  = head[ibBusPkg::dataW-1:0];
  assign headSop   = head[ibBusPkg::sopPos];
  assign headEop   = head[ibBusPkg::eopPos];
  assign headValid = (fill != '0);                         // anything stored shows next cycle.

  // ********************
  // address decode
  // ********************
  assign hitPort1 = ibBusPkg::windowMatch(headData, port1Base, windowBits);
  assign hitPort2 = ibBusPkg::windowMatch(headData, port2Base, windowBits);

  always_comb begin
    if (hitPort1) begin
      newDest = 3'b010;                                    // port 1 window.
    end else if (hitPort2) begin
      newDest = 3'b100;                                    // port 2 window.
    end else begin
      newDest = 3'b001;                                    // everything else goes upstream.
    end
    // a packet aimed back at its own port is dropped; for port 0 this also
    // covers an address that misses both windows.
    if (newDest[port]) begin
      newDest = '0;
    end
  end

  assign headDest = headSop ? newDest : destReg;           // live on the start word, held after.
  assign drain    = headValid && (headDest == '0);         // no output will ever pop these.
  assign doPop    = pop || drain;

  // ********************
  // storage and pointers
  // ********************
  always_ff @(posedge CLK) begin
    if (rxValid) begin
      mem[wrPtr] <= {rxEop, rxSop, rxData};                // layout matches eopPos and sopPos.
    end
  end

  always_ff @(posedge CLK) begin
    if (!rstN) begin
      wrPtr    <= '0;
      rdPtr    <= '0;
      fill     <= '0;
      rxCredit <= 1'b0;
      destReg  <= '0;
    end else begin
      if (rxValid) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({rxValid, doPop})
        2'b10:   fill <= fill + 1'b1;                      // write only.
        2'b01:   fill <= fill - 1'b1;                      // read only.
        default: fill <= fill;                             // both or neither.
      endcase
      rxCredit <= doPop;                                   // one credit per freed word.
      if (doPop && headSop) begin
        destReg <= newDest;                                // held until the end word leaves.
      end
    end
  end

  // ********************
  // protocol checks
  // ********************
  // the remote sender's credits must keep it from writing into a full buffer.
  rxNotFull : assert property (@(posedge CLK) disable iff (!rstN)
    rxValid |-> (fill != fullLvl))
    else $error("ibInputPort %0d: rxValid while buffer full", port);

  // only a granted output pops, and only a word that is there.
  popNotEmpty : assert property (@(posedge CLK) disable iff (!rstN)
    pop |-> headValid)
    else $error("ibInputPort %0d: pop with empty head", port);

endmodule

`default_nettype wire

// ==== rtl/ibOutputPort.sv ====
`timescale 1ns/1ns
`default_nettype none

module ibOutputPort #(
  parameter int                  txCredits = 8,
  parameter ibSwitchPkg::portIdx port      = '0
) (
  input  logic             CLK,
  input  logic             rstN,
  input  ibBusPkg::busData srcData [2],
  input  logic [1:0]       srcSop,
  input  logic [1:0]       srcEop,
  input  logic [1:0]       srcValid,
  input  logic [1:0]       srcWant,
  input  logic             txCredit,
  output logic [1:0]       srcPop,
  output ibBusPkg::busData txData,
  output logic             txSop,
  output logic             txEop,
  output logic             txValid
);

  localparam ibSwitchPkg::creditCnt fullCredit = ibSwitchPkg::creditCnt'(txCredits);

  ibSwitchPkg::arbState  state;             // idle or holding a grant.
  ibSwitchPkg::creditCnt cnt;               // credits left on the transmit link.
  logic                  sel;               // source granted while busy.
  logic                  prio;              // source preferred at the next grant.
  logic [1:0]            req;               // start words aimed at this port.
  logic                  pick;              // round robin winner.
  logic                  grantSrc;          // source served this cycle.
  logic                  active;            // a source is granted this cycle.
  logic                  popNow;            // a word moves this cycle.
  logic                  lastWord;          // that word closes the packet.

  // ********************
  // arbitration
  // ********************
  assign req  = srcValid & srcSop & srcWant;
  assign pick = req[prio] ? prio : ~prio;                  // fall back to the other source.

  always_comb begin
    if (state == ibSwitchPkg::arbBusy) begin
      grantSrc = sel;                                      // keep the packet owner.
      active   = 1'b1;
    end else begin
      grantSrc = pick;                                     // grant and first pop share a cycle.
      active   = |req;
    end
  end

  assign popNow   = active && srcValid[grantSrc] && (cnt != '0); // stall on empty head or credits.
  assign lastWord = popNow && srcEop[grantSrc];
  assign srcPop   = popNow ? (2'b01 << grantSrc) : 2'b00;

  always_ff @(posedge CLK) begin
    if (!rstN) begin
      state   <= ibSwitchPkg::arbIdle;
      sel     <= 1'b0;
      prio    <= 1'b0;
      cnt     <= fullCredit;                               // the receiver's depth.
      txValid <= 1'b0;
    end else begin
      txValid <= popNow;                                   // word shows the cycle after its pop.
      case ({popNow, txCredit})
        2'b10:   cnt <= cnt - 1'b1;                        // spend one.
        2'b01:   cnt <= cnt + 1'b1;                        // one returned.
        default: cnt <= cnt;                               // spend and return cancel.
      endcase
      if (lastWord) begin
        state <= ibSwitchPkg::arbIdle;
        prio  <= ~grantSrc;                                // other source goes first next time.
      end else if (popNow && (state == ibSwitchPkg::arbIdle)) begin
        state <= ibSwitchPkg::arbBusy;
        sel   <= grantSrc;
      end
    end
  end

  // ********************
  // transmit register
  // ********************
  always_ff @(posedge CLK) begin
    if (popNow) begin
      txData <= srcData[grantSrc];
      txSop  <= srcSop[grantSrc];
      txEop  <= srcEop[grantSrc];
    end
  end

  // ********************
  // credit checks
  // ********************
  // a word on the link has not had its credit back yet.
  txHadCredit : assert property (@(posedge CLK) disable iff (!rstN)
    txValid |-> (cnt < fullCredit))
    else $error("ibOutputPort %0d: credit back before its word was sent", port);

  // the receiver never returns more than it was given.
  creditBound : assert property (@(posedge CLK) disable iff (!rstN)
    cnt <= fullCredit)
    else $error("ibOutputPort %0d: credit count above txCredits", port);

endmodule

`default_nettype wire

// ==== rtl/ibSwitch.sv ====
`timescale 1ns/1ns
`default_nettype none

module ibSwitch #(
  parameter int               bufDepth   = 8,
  parameter int               txCredits  = 8,
  parameter ibBusPkg::busAddr port1Base  = 32'h0001_0000,
  parameter ibBusPkg::busAddr port2Base  = 32'h0002_0000,
  parameter int               windowBits = 16
) (
  input  logic                                CLK,
  input  logic                                rstN,
  input  ibBusPkg::busData                    rxData [ibSwitchPkg::numPorts],
  input  logic [ibSwitchPkg::numPorts-1:0]    rxSop,
  input  logic [ibSwitchPkg::numPorts-1:0]    rxEop,
  input  logic [ibSwitchPkg::numPorts-1:0]    rxValid,
  output logic [ibSwitchPkg::numPorts-1:0]    rxCredit,
  output ibBusPkg::busData                    txData [ibSwitchPkg::numPorts],
  output logic [ibSwitchPkg::numPorts-1:0]    txSop,
  output logic [ibSwitchPkg::numPorts-1:0]    txEop,
  output logic [ibSwitchPkg::numPorts-1:0]    txValid,
  input  logic [ibSwitchPkg::numPorts-1:0]    txCredit
);

  localparam int nP = ibSwitchPkg::numPorts;

  ibBusPkg::busData     headData [nP];      // head word of each input buffer.
  logic [nP-1:0]        headSop;
  logic [nP-1:0]        headEop;
  logic [nP-1:0]        headValid;
  ibSwitchPkg::portMask headDest [nP];      // destination of each head packet.
  logic [nP-1:0]        inPop;              // merged pop per input.
  logic [1:0]           outPop [nP];        // pops issued by each output, per source slot.

  // ********************
  // receive side
  // ********************
  for (genvar i = 0; i < nP; i++) begin : genIn
    ibInputPort #(
      .bufDepth   (bufDepth),
      .port       (ibSwitchPkg::portIdx'(i)),
      .port1Base  (port1Base),
      .port2Base  (port2Base),
      .windowBits (windowBits)
    ) inPort (
      .CLK       (CLK),
      .rstN      (rstN),
      .rxData    (rxData[i]),
      .rxSop     (rxSop[i]),
      .rxEop     (rxEop[i]),
      .rxValid   (rxValid[i]),
      .pop       (inPop[i]),
      .rxCredit  (rxCredit[i]),
      .headData  (headData[i]),
      .headSop   (headSop[i]),
      .headEop   (headEop[i]),
      .headValid (headValid[i]),
      .headDest  (headDest[i])
    );

    // input i is slot 0 of output i-1 and slot 1 of output i+1.
    assign inPop[i] = outPop[(i + 2) % nP][0] | outPop[(i + 1) % nP][1];
  end

  // ********************
  // transmit side
  // ********************
  for (genvar o = 0; o < nP; o++) begin : genOut
    localparam int s0 = (o + 1) % nP;       // first source, next port up.
    localparam int s1 = (o + 2) % nP;       // second source.

    ibBusPkg::busData srcData [2];
    logic [1:0]       srcWant;

    assign srcData[0] = headData[s0];
    assign srcData[1] = headData[s1];
    assign srcWant    = {headDest[s1][o], headDest[s0][o]}; // mask bit for this output.

    ibOutputPort #(
      .txCredits (txCredits),
      .port      (ibSwitchPkg::portIdx'(o))
    ) outPort (
      .CLK      (CLK),
      .rstN     (rstN),
      .srcData  (srcData),
      .srcSop   ({headSop[s1], headSop[s0]}),
      .srcEop   ({headEop[s1], headEop[s0]}),
      .srcValid ({headValid[s1], headValid[s0]}),
      .srcWant  (srcWant),
      .txCredit (txCredit[o]),
      .srcPop   (outPop[o]),
      .txData   (txData[o]),
      .txSop    (txSop[o]),
      .txEop    (txEop[o]),
      .txValid  (txValid[o])
    );
  end

endmodule

`default_nettype wire

// ==== rtl/ibSwitchPkg.sv ====
`default_nettype none

package ibSwitchPkg;

  // ********************
  // switch geometry
  // ********************
  localparam int numPorts = 3;                 // port 0 upstream, ports 1 and 2 downstream.

  typedef logic [1:0] portIdx;                 // port number 0 to 2.
  typedef logic [numPorts-1:0] portMask;       // one-hot destination, zero means discard.

  // ********************
  // flow control and arbitration
  // ********************
  typedef logic [4:0] creditCnt;               // holds credit depths up to 16.

  typedef enum logic {
    arbIdle,                                   // no packet granted.
    arbBusy                                    // packet in flight, grant held.
  } arbState;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module ibSwitchTb -f ibSwitch.f -o ibSwitchSim \
  && ./obj_dir/ibSwitchSim | tee /dev/stderr | grep -qx "PASS: all tests" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== testbench/ibSwitchTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module ibSwitchTb;

  localparam int          bufDepth       = 8;
  localparam int          txCredits      = 4;
  localparam logic [31:0] port1Base      = 32'h0001_0000;
  localparam logic [31:0] port2Base      = 32'h0002_0000;
  localparam int          windowBits     = 16;
  localparam int          totalPkts      = 91;              // packets queued over all tests.
  localparam int          watchdogCycles = totalPkts * 6 * 40;

  logic             CLK = 1'b0;
  logic             rstN = 1'b0;
  ibBusPkg::busData rxData [3] = '{default: '0};
  logic [2:0]       rxSop = '0;
  logic [2:0]       rxEop = '0;
  logic [2:0]       rxValid = '0;
  logic [2:0]       rxCredit;
  ibBusPkg::busData txData [3];
  logic [2:0]       txSop;
  logic [2:0]       txEop;
  logic [2:0]       txValid;
  logic [2:0]       txCredit = '0;

  logic [35:0] pend [3][$];                      // words to send as {dest, eop, sop, data}.
  logic [33:0] expQ [9][$];                      // expected {eop, sop, data} at src*3+dest.
  time         sopTime [9][$];                   // drive time of each queued header.
  int          credit [3] = '{default: bufDepth}; // sender model credits.
  int          owed [3] = '{default: 0};         // credits still to return to the DUT.
  int          sentCnt [3] = '{default: 0};      // words seen per transmit link.
  int          givenCnt [3] = '{default: 0};     // credits returned per transmit link.
  int          seqNo [3] = '{default: 0};        // payload sequence per source.
  int          curSrc [3] = '{default: 0};       // owner of the packet on each link.
  logic [2:0]  inPkt = '0;
  int          lastSrc0 = 0;                     // source of the last packet on port 0.
  time         lastEop0 = 0;
  logic        havePrev0 = 1'b0;
  logic        hold = 1'b0;                      // withhold transmit credits.
  logic        noIdle = 1'b0;                    // senders push every cycle they can.
  logic        contention = 1'b0;                // fairness check on port 0 armed.
  int          errors = 0;
  int          errBase = 0;
  int          testsRun = 0;
  int          testsFailed = 0;
  int unsigned rngState = 58701;

  ibSwitch #(
    .bufDepth   (bufDepth),
    .txCredits  (txCredits),
    .port1Base  (port1Base),
    .port2Base  (port2Base),
    .windowBits (windowBits)
  ) uut (
    .CLK      (CLK),
    .rstN     (rstN),
    .rxData   (rxData),
    .rxSop    (rxSop),
    .rxEop    (rxEop),
    .rxValid  (rxValid),
    .rxCredit (rxCredit),
    .txData   (txData),
    .txSop    (txSop),
    .txEop    (txEop),
    .txValid  (txValid),
    .txCredit (txCredit)
  );

  initial begin
    forever #2 CLK = ~CLK;                       // 4 ns period.
  end

  initial begin
    repeat (watchdogCycles) @(posedge CLK);
    $display("timeout: traffic did not complete in %0d cycles", watchdogCycles);
    $display("FAIL: see errors above");
    $finish;
  end

  // ********************
  // helpers
  // ********************
  function automatic int unsigned nextRand();
    rngState = rngState * 32'd1664525 + 32'd1013904223;     // LCG step.
    return rngState >> 8;                                   // low bits are weak.
  endfunction

  // destination by the routing rule.
  // 3 marks a dropped packet.
  function automatic int routeOf(input int src, input logic [31:0] addr);
    int dst;
    if ((addr >> windowBits) == (port1Base >> windowBits)) dst = 1;
    else if ((addr >> windowBits) == (port2Base >> windowBits)) dst = 2;
    else dst = 0;
    if (dst == src) dst = 3;                                // back to its own port.
    return dst;
  endfunction

  task automatic expectTrue(input logic cond, input string msg);
    assert (cond) else begin
      errors++;
      $display("%0t: %s", $time, msg);
    end
  endtask

  task automatic expectEq(input string sig, input logic [35:0] want, input logic [35:0] got);
    assert (got == want) else begin
      errors++;
      $display("ERROR at %0t: %s expected %h, got %h", $time, sig, want, got);
    end
  endtask

  // kind is the aimed port.
  // kind 0 aims outside both windows.
  task automatic queuePacket(input int src, input int kind);
    logic [31:0] addr;
    logic [31:0] w;
    int          len;
    int          dst;
    int          i;
    if (kind == 1) addr = port1Base;
    else if (kind == 2) addr = port2Base;
    else addr = 32'h3000_0000 | ((nextRand() & 32'hfff) << 16);
    addr = addr | (32'(src) << 14) | (nextRand() & 32'h3fff); // source in bits 15:14.
    dst  = routeOf(src, addr);
    len  = 2 + int'(nextRand() % 5);
    for (i = 0; i < len; i++) begin
      if (i == 0) begin
        w = addr;
      end else begin
        w = {src[1:0], 6'd0, 8'(i), 16'(seqNo[src])};       // source in the top bits.
        seqNo[src]++;
      end
      pend[src].push_back({2'(dst), i == len - 1, i == 0, w});
    end
  endtask

  task automatic queueTraffic(input int src, input int count, input int mode);
    int i;
    int kind;
    for (i = 0; i < count; i++) begin
      case (mode)
        0:       kind = (src + 1 + int'(nextRand() % 2)) % 3; // always a valid route.
        1:       kind = (i % 2 == 0) ? src : (src + 1) % 3;   // every other packet dropped.
        2:       kind = 0;                                    // upstream only.
        default: kind = int'(nextRand() % 3);
      endcase
      queuePacket(src, kind);
    end
  endtask

  // ********************
  // link models
  // ********************
  task automatic checkTxWord(input int p);
    int          src;
    int          q;
    int          alt;
    logic [33:0] want;
    sentCnt[p]++;
    expectTrue(sentCnt[p] <= txCredits + givenCnt[p],
               $sformatf("port %0d sent a word it had no credit for", p));
    src = int'(txSop[p] ? txData[p][15:14] : txData[p][31:30]);
    if (txSop[p]) begin
      expectTrue(!inPkt[p], $sformatf("port %0d started a packet inside another", p));
      if (p == 0 && contention && havePrev0 && lastSrc0 != 0 && lastSrc0 < 3) begin
        alt = 3 - lastSrc0;                                 // source whose turn it is.
        if (sopTime[alt * 3].size() > 0 && sopTime[alt * 3][0] + 4 <= lastEop0) begin
          expectTrue(src == alt,
                     $sformatf("port 0 served source %0d twice while %0d waited", src, alt));
        end
      end
      inPkt[p]  = 1'b1;
      curSrc[p] = src;
    end else begin
      expectTrue(inPkt[p] && src == curSrc[p], $sformatf("port %0d interleaved packets", p));
    end
    q = src * 3 + p;
    if (src > 2 || expQ[q].size() == 0) begin
      expectTrue(1'b0, $sformatf("unexpected word %h on port %0d", txData[p], p));
    end else begin
      want = expQ[q].pop_front();
      if (want[32]) void'(sopTime[q].pop_front());
      expectEq($sformatf("txData[%0d]", p), 36'(want), 36'({txEop[p], txSop[p], txData[p]}));
    end
    if (txEop[p]) begin
      inPkt[p] = 1'b0;
      if (p == 0) begin
        lastSrc0  = src;
        lastEop0  = $time;
        havePrev0 = 1'b1;
      end
    end
    owed[p]++;                                              // buffer word freed downstream.
  endtask

  // one clock cycle of every link model.
  // all inputs change on the falling edge.
  task automatic tick();
    int          p;
    int          q;
    logic [35:0] ent;
    @(negedge CLK);
    if (!rstN) begin
      expectEq("txValid", 36'(0), 36'(txValid));
      expectEq("rxCredit", 36'(0), 36'(rxCredit));
    end else begin
      for (p = 0; p < 3; p++) begin
        if (rxCredit[p]) credit[p]++;                       // each pulse returns one credit.
        if (pend[p].size() > 0 && credit[p] > 0 && (noIdle || nextRand() % 4 != 0)) begin
          ent = pend[p].pop_front();
          rxData[p]  = ent[31:0];
          rxSop[p]   = ent[32];
          rxEop[p]   = ent[33];
          rxValid[p] = 1'b1;
          credit[p]--;
          if (ent[35:34] != 2'd3) begin
            q = p * 3 + int'(ent[35:34]);
            expQ[q].push_back(ent[33:0]);
            if (ent[32]) sopTime[q].push_back($time);
          end
        end else begin
          rxValid[p] = 1'b0;
        end
        if (txValid[p]) checkTxWord(p);
        if (!hold && owed[p] > 0 && nextRand() % 3 != 0) begin // random return delay.
          txCredit[p] = 1'b1;
          owed[p]--;
          givenCnt[p]++;
        end else begin
          txCredit[p] = 1'b0;
        end
      end
    end
  endtask

  function automatic logic settled();
    int p;
    for (p = 0; p < 3; p++) begin
      if (credit[p] != bufDepth || owed[p] != 0) return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic drainAll();
    int   p;
    int   n;
    logic busy;
    busy = 1'b1;
    while (busy) begin
      tick();
      busy = 1'b0;
      for (p = 0; p < 3; p++) if (pend[p].size() > 0 || inPkt[p]) busy = 1'b1;
      for (p = 0; p < 9; p++) if (expQ[p].size() > 0) busy = 1'b1;
    end
    for (n = 0; n < 64 && !settled(); n++) tick();          // dropped words and late credits.
    for (p = 0; p < 3; p++) begin
      expectEq($sformatf("sender credit %0d", p), 36'(bufDepth), 36'(credit[p]));
    end
  endtask

  task automatic report(input int num, input string name);
    testsRun++;
    if (errors == errBase) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      testsFailed++;
      $display("test %0d %s: failed with %0d errors", num, name, errors - errBase);
    end
    errBase = errors;
  endtask

  // ********************
  // test sequence
  // ********************
  initial begin
    repeat (16) tick();                                     // reset held low.
    rstN = 1'b1;
    tick();
    expectEq("txValid", 36'(0), 36'(txValid));              // first cycle out of reset.
    report(1, "reset");

    for (int s = 0; s < 3; s++) queueTraffic(s, 6, 0);
    drainAll();
    report(2, "routing");

    for (int s = 0; s < 3; s++) queueTraffic(s, 6, 1);
    drainAll();
    report(3, "discard");

    noIdle     = 1'b1;
    contention = 1'b1;
    havePrev0  = 1'b0;
    queueTraffic(1, 8, 2);
    queueTraffic(2, 8, 2);
    drainAll();
    contention = 1'b0;
    noIdle     = 1'b0;
    report(4, "contention");

    for (int s = 0; s < 3; s++) queueTraffic(s, 8, 3);
    drainAll();
    report(5, "credits");

    hold = 1'b1;                                            // starve every transmit link.
    for (int s = 0; s < 3; s++) queueTraffic(s, 5, 0);
    repeat (100) tick();
    hold = 1'b0;
    drainAll();
    report(6, "back-pressure");

    $display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire
